/* dv/pet_stimulus.txt */
# Columns: health feed play tilt test(active low) ticks | need happy sleep seg(g..a) test_led
# ticks and need are decimal, everything else binary; need 0 health 1 energy 2 hunger 3 fun
0 0 0 1 1 1  0 1 0 0000000 0
0 1 0 1 1 3  2 1 0 0001000 0
0 0 0 1 1 20 2 1 0 0001000 0
1 0 0 1 1 1  0 1 0 0000000 0
0 0 0 1 1 48 0 1 0 0000010 0
0 0 0 0 1 11 1 1 1 0010010 0
0 0 0 0 1 1  1 1 1 0000010 0
0 0 1 1 1 5  3 1 0 0010010 0
0 0 1 1 1 1  3 1 0 0000010 0
1 0 0 1 1 1  0 1 0 1111000 0
0 0 0 1 1 48 0 1 0 0010010 0
0 0 0 1 1 23 0 1 0 0010010 0
0 0 0 1 1 1  0 0 0 0011001 0
0 0 0 1 0 1  0 0 0 0011001 1
1 0 0 1 1 1  0 0 0 1111001 1
1 0 0 1 1 1  0 1 0 0001000 1
1 0 0 1 1 2  0 1 0 0001000 1
0 0 0 1 1 48 0 1 0 0001000 1
0 0 0 0 1 12 0 1 0 0001000 1
0 1 0 1 1 1  2 0 0 1111001 1

/* dv/pet_top_tb.sv */
`timescale 1ns/1ps

module pet_top_tb;

    localparam int SIM_DIVISOR  = 4;
    localparam int MAX_STEPS    = 64;
    localparam int TICK_TIMEOUT = 4 * SIM_DIVISOR; // Cycles allowed between two ticks

    // One line of the stimulus file
    typedef struct packed {
        logic       health;
        logic       feed;
        logic       play;
        logic       tilt;
        logic       test;     // Active low button
        int         ticks;    // Ticks to hold the inputs
        logic [1:0] need;
        logic       happy;
        logic       sleep;
        logic [6:0] seg;
        logic       test_led;
    } step_t;

    logic       clk;
    logic       btn_reset;
    logic       btn_health;
    logic       btn_feed;
    logic       play_sensor;
    logic       tilt;
    logic       btn_test;
    logic [1:0] need_sel;
    logic       happy;
    logic       sleep;
    logic [6:0] seg_display;
    logic       test_led;

    step_t steps [MAX_STEPS];
    int    num_steps;
    int    checks;
    int    errors;
    bit    timed_out;

    pet_top #(.TICK_DIVISOR(SIM_DIVISOR)) pet_top_inst (
        .clk         (clk),
        .btn_reset   (btn_reset),
        .btn_health  (btn_health),
        .btn_feed    (btn_feed),
        .play_sensor (play_sensor),
        .tilt        (tilt),
        .btn_test    (btn_test),
        .need_sel    (need_sel),
        .happy       (happy),
        .sleep       (sleep),
        .seg_display (seg_display),
        .test_led    (test_led)
    );

    always #2 clk = ~clk; // 4 ns period

    task automatic load_steps();
        int    fd;
        int    fields;
        int    col [11];
        string line;
        fd = $fopen("dv/pet_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/pet_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && num_steps < MAX_STEPS) begin
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%b %b %b %b %b %d %d %b %b %b %b",
                                     col[0], col[1], col[2], col[3], col[4], col[5],
                                     col[6], col[7], col[8], col[9], col[10]);
                    if (fields != 11) begin
                        $display("stimulus line could not be parsed: %s", line);
                        errors++;
                    end else begin
                        steps[num_steps].health   = col[0][0];
                        steps[num_steps].feed     = col[1][0];
                        steps[num_steps].play     = col[2][0];
                        steps[num_steps].tilt     = col[3][0];
                        steps[num_steps].test     = col[4][0];
                        steps[num_steps].ticks    = col[5];
                        steps[num_steps].need     = col[6][1:0];
                        steps[num_steps].happy    = col[7][0];
                        steps[num_steps].sleep    = col[8][0];
                        steps[num_steps].seg      = col[9][6:0];
                        steps[num_steps].test_led = col[10][0];
                        num_steps++;
                    end
                end
            end
            $fclose(fd);
            if (num_steps == 0) begin
                $display("the stimulus file holds no steps");
                errors++;
            end
        end
    endtask

    task automatic apply_pins(input step_t row);
        btn_health  = row.health;
        btn_feed    = row.feed;
        play_sensor = row.play;
        tilt        = row.tilt;
        btn_test    = row.test;
    endtask

    // Returns on the falling edge inside the last counted tick
    task automatic wait_ticks(input int count);
        int seen;
        int idle;
        seen = 0;
        idle = 0;
        while (seen < count && !timed_out) begin
            @(negedge clk);
            if (pet_top_inst.tick) begin
                seen++;
                idle = 0;
            end else if (++idle > TICK_TIMEOUT) begin
                $display("timeout: no tick from the DUT within %0d cycles at %0t", idle, $time);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("error at %0t: %s expected %0b actual %0b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_step(input step_t row);
        compare_field("need_sel", 32'(row.need), 32'(need_sel));
        compare_field("happy", 32'(row.happy), 32'(happy));
        compare_field("sleep", 32'(row.sleep), 32'(sleep));
        compare_field("seg_display", 32'(row.seg), 32'(seg_display));
        compare_field("test_led", 32'(row.test_led), 32'(test_led));
    endtask

    initial begin
        int i;
        clk         = 1'b0;
        btn_reset   = 1'b0;
        btn_health  = 1'b0;
        btn_feed    = 1'b0;
        play_sensor = 1'b0;
        tilt        = 1'b1; // Pet upright
        btn_test    = 1'b1; // Test button released
        num_steps   = 0;
        checks      = 0;
        errors      = 0;
        timed_out   = 1'b0;
        load_steps();
        if (num_steps > 0) begin
            apply_pins(steps[0]);
        end
        repeat (4) @(negedge clk);
        btn_reset = 1'b1;
        for (i = 0; i < num_steps && !timed_out; i++) begin
            wait_ticks(steps[i].ticks);
            if (!timed_out) begin
                repeat (2) @(negedge clk);
                // Next pins reach the core right at the following tick
                if (i + 1 < num_steps) begin
                    apply_pins(steps[i + 1]);
                end
                @(negedge clk); // Outputs settled 3 cycles after the tick
                check_step(steps[i]);
            end
        end
        $display("checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the pet controller testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module pet_top_tb -Mdir obj_dir > build.log 2>&1 \
    && ./obj_dir/Vpet_top_tb > "$LOG" 2>&1 \
    || { echo "Build or run failed, see build.log and $LOG"; exit 1; }

grep -qx "STATUS: PASS" "$LOG" \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see $LOG"; exit 1; }

/* source/input_sync.sv */
`timescale 1ns/1ps

module input_sync (
    input  logic                 clk,
    input  logic                 btn_reset,
    input  logic                 btn_health,
    input  logic                 btn_feed,
    input  logic                 play_sensor,
    input  logic                 tilt,
    input  logic                 btn_test,
    output pet_pkg::pet_inputs_t inputs
);

    // Pin order {health, feed, play, tilt, test}
    localparam logic [4:0] IDLE_PINS = 5'b00011; // Upright, test button released

    logic [4:0] pins;
    logic [4:0] meta;
    logic [4:0] stable;
    logic       test_last;

    assign pins = {btn_health, btn_feed, play_sensor, tilt, btn_test};

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            meta      <= IDLE_PINS;
            stable    <= IDLE_PINS;
            test_last <= 1'b1;
        end else begin
            meta      <= pins;
            stable    <= meta;
            test_last <= stable[0]; // Previous synchronized test sample
        end
    end

    assign inputs.health     = stable[4];
    assign inputs.feed       = stable[3];
    assign inputs.play       = stable[2];
    assign inputs.tilt       = stable[1];
    assign inputs.test_press = test_last & ~stable[0]; // Falling edge, button is active low

endmodule

/* source/need_counter.sv */
`timescale 1ns/1ps
`include "pet_defines.svh"

module need_counter #(
    parameter int CARE_TICKS = 1
) (
    input  logic            clk,
    input  logic            btn_reset,
    input  logic            tick,
    input  logic            care,
    input  logic            decay_en,
    input  logic            test_mode,
    output pet_pkg::level_t level
);

    localparam int CARE_W  = $clog2(CARE_TICKS + 1);
    localparam int DECAY_W = $clog2(`PET_DECAY_TICKS + 1);

    localparam pet_pkg::level_t LVL_MIN   = pet_pkg::level_t'(`PET_LEVEL_MIN);
    localparam pet_pkg::level_t LVL_MAX   = pet_pkg::level_t'(`PET_LEVEL_MAX);
    localparam pet_pkg::level_t LVL_RESET = pet_pkg::level_t'(`PET_LEVEL_RESET);

    logic [CARE_W-1:0]  care_timer;
    logic [CARE_W-1:0]  care_next;
    logic [DECAY_W-1:0] decay_timer;
    logic [DECAY_W-1:0] decay_next;
    logic               care_done;
    logic               decay_done;

    assign care_next  = care_timer + 1'b1;
    assign decay_next = decay_timer + 1'b1;
    assign care_done  = (care_next == CARE_W'(CARE_TICKS));
    assign decay_done = (decay_next == DECAY_W'(`PET_DECAY_TICKS));

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            level       <= LVL_RESET;
            care_timer  <= '0;
            decay_timer <= '0;
        end else if (tick) begin
            if (test_mode) begin
                // Test mode jumps between the extremes, no decay
                if (care) begin
                    level <= (level == LVL_MIN) ? LVL_MAX : LVL_MIN;
                end
            end else if (care) begin
                if (care_done) begin
                    if (level < LVL_MAX) begin
                        level <= level + 1'b1;
                    end
                    care_timer  <= '0;
                    decay_timer <= '0; // Fresh care restarts the decay period
                end else begin
                    care_timer <= care_next;
                end
            end else if (decay_en) begin
                if (decay_done) begin
                    if (level > LVL_MIN) begin
                        level <= level - 1'b1;
                    end
                    decay_timer <= '0;
                end else begin
                    decay_timer <= decay_next;
                end
            end
        end
    end

endmodule

/* source/pet_core.sv */
`timescale 1ns/1ps
`include "pet_defines.svh"

module pet_core (
    input  logic                 clk,
    input  logic                 btn_reset,
    input  logic                 tick,
    input  pet_pkg::pet_inputs_t inputs,
    output pet_pkg::pet_view_t   view,
    output logic                 test_led
);

    localparam pet_pkg::level_t HAPPY_LVL = pet_pkg::level_t'(`PET_HAPPY_THRESHOLD);
    localparam pet_pkg::level_t LVL_RESET = pet_pkg::level_t'(`PET_LEVEL_RESET);

    logic            test_mode;
    logic            energy_care;
    pet_pkg::need_e  need_sel;
    pet_pkg::level_t health_level;
    pet_pkg::level_t energy_level;
    pet_pkg::level_t hunger_level;
    pet_pkg::level_t fun_level;
    pet_pkg::level_t sel_level;

    assign energy_care = ~inputs.tilt & ~test_mode; // Lying down is rest, not in test mode
    assign test_led    = test_mode;

    need_counter #(.CARE_TICKS(1)) health_inst (
        .clk       (clk),
        .btn_reset (btn_reset),
        .tick      (tick),
        .care      (inputs.health),
        .decay_en  (1'b1),
        .test_mode (test_mode),
        .level     (health_level)
    );

    need_counter #(.CARE_TICKS(1)) hunger_inst (
        .clk       (clk),
        .btn_reset (btn_reset),
        .tick      (tick),
        .care      (inputs.feed),
        .decay_en  (1'b1),
        .test_mode (test_mode),
        .level     (hunger_level)
    );

    need_counter #(.CARE_TICKS(`PET_CARE_TICKS_FUN)) fun_inst (
        .clk       (clk),
        .btn_reset (btn_reset),
        .tick      (tick),
        .care      (inputs.play),
        .decay_en  (1'b1),
        .test_mode (test_mode),
        .level     (fun_level)
    );

    // Energy only drains while the pet is upright
    need_counter #(.CARE_TICKS(`PET_CARE_TICKS_SLEEP)) energy_inst (
        .clk       (clk),
        .btn_reset (btn_reset),
        .tick      (tick),
        .care      (energy_care),
        .decay_en  (inputs.tilt),
        .test_mode (test_mode),
        .level     (energy_level)
    );

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            test_mode <= 1'b0;
        end else if (inputs.test_press) begin
            test_mode <= 1'b1; // Sticky until reset
        end
    end

    // Most recently attended need, fixed priority on a tie
    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            need_sel <= pet_pkg::NEED_HEALTH;
        end else if (tick) begin
            if (inputs.health) begin
                need_sel <= pet_pkg::NEED_HEALTH;
            end else if (inputs.feed) begin
                need_sel <= pet_pkg::NEED_HUNGER;
            end else if (inputs.play) begin
                need_sel <= pet_pkg::NEED_FUN;
            end else if (energy_care) begin
                need_sel <= pet_pkg::NEED_ENERGY;
            end
        end
    end

    always_comb begin
        case (need_sel)
            pet_pkg::NEED_HEALTH: sel_level = health_level;
            pet_pkg::NEED_ENERGY: sel_level = energy_level;
            pet_pkg::NEED_HUNGER: sel_level = hunger_level;
            default:              sel_level = fun_level;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            view.need  <= pet_pkg::NEED_HEALTH;
            view.happy <= (LVL_RESET >= HAPPY_LVL);
            view.sleep <= 1'b0;
            view.level <= LVL_RESET;
        end else begin
            view.need  <= need_sel;
            view.happy <= (sel_level >= HAPPY_LVL);
            view.sleep <= energy_care; // Already masked by test mode
            view.level <= sel_level;
        end
    end

endmodule

/* source/pet_defines.svh */
`ifndef PET_DEFINES_SVH
`define PET_DEFINES_SVH

// Tick pacing, clk cycles per tick on the board
`define PET_TICK_DIVISOR 7500000

// Level range of every need
`define PET_LEVEL_MIN 1
`define PET_LEVEL_MAX 10
`define PET_LEVEL_RESET 8

// Ticks without care before a level drops by one
`define PET_DECAY_TICKS 24

// Ticks of held care per level step, health and hunger step every tick
`define PET_CARE_TICKS_FUN 6
`define PET_CARE_TICKS_SLEEP 12

// Lowest level that still shows a happy face
`define PET_HAPPY_THRESHOLD 5

`endif

/* source/pet_pkg.sv */
package pet_pkg;

    // 4-bit need level, 1 to 10 in use
    typedef logic [3:0] level_t;

    // Need codes as shown on the need_sel pins
    typedef enum logic [1:0] {
        NEED_HEALTH = 2'd0,
        NEED_ENERGY = 2'd1,
        NEED_HUNGER = 2'd2,
        NEED_FUN    = 2'd3
    } need_e;

    // Synchronized pin levels seen by the core
    typedef struct packed {
        logic health;     // Health button held
        logic feed;       // Feed button held
        logic play;       // Play sensor active
        logic tilt;       // High while the pet is upright
        logic test_press; // One cycle pulse on a test button press
    } pet_inputs_t;

    // What the pet currently shows
    typedef struct packed {
        need_e  need;  // Most recently attended need
        logic   happy; // Selected level at or above threshold
        logic   sleep; // Pet lying down outside test mode
        level_t level; // Level of the selected need
    } pet_view_t;

endpackage

/* source/pet_top.sv */
`timescale 1ns/1ps
`include "pet_defines.svh"

module pet_top #(
    parameter int TICK_DIVISOR = `PET_TICK_DIVISOR
) (
    input  logic       clk,
    input  logic       btn_reset,
    input  logic       btn_health,
    input  logic       btn_feed,
    input  logic       play_sensor,
    input  logic       tilt,
    input  logic       btn_test,
    output logic [1:0] need_sel,
    output logic       happy,
    output logic       sleep,
    output logic [6:0] seg_display,
    output logic       test_led
);

    logic                 tick;
    pet_pkg::pet_inputs_t inputs;
    pet_pkg::pet_view_t   view;

    tick_divider #(.DIVISOR(TICK_DIVISOR)) tick_divider_inst (
        .clk       (clk),
        .btn_reset (btn_reset),
        .tick      (tick)
    );

    input_sync input_sync_inst (
        .clk         (clk),
        .btn_reset   (btn_reset),
        .btn_health  (btn_health),
        .btn_feed    (btn_feed),
        .play_sensor (play_sensor),
        .tilt        (tilt),
        .btn_test    (btn_test),
        .inputs      (inputs)
    );

    pet_core pet_core_inst (
        .clk       (clk),
        .btn_reset (btn_reset),
        .tick      (tick),
        .inputs    (inputs),
        .view      (view),
        .test_led  (test_led)
    );

    seven_seg_encoder seven_seg_encoder_inst (
        .clk         (clk),
        .btn_reset   (btn_reset),
        .level       (view.level),
        .seg_display (seg_display)
    );

    assign need_sel = view.need;
    assign happy    = view.happy;
    assign sleep    = view.sleep;

endmodule

/* source/seven_seg_encoder.sv */
`timescale 1ns/1ps

module seven_seg_encoder (
    input  logic            clk,
    input  logic            btn_reset,
    input  pet_pkg::level_t level,
    output logic [6:0]      seg_display
);

    // Active low, segment g in bit 6
    logic [6:0] seg_next;

    always_comb begin
        case (level)
            4'd0:    seg_next = 7'b1000000;
            4'd1:    seg_next = 7'b1111001;
            4'd2:    seg_next = 7'b0100100;
            4'd3:    seg_next = 7'b0110000;
            4'd4:    seg_next = 7'b0011001;
            4'd5:    seg_next = 7'b0010010;
            4'd6:    seg_next = 7'b0000010;
            4'd7:    seg_next = 7'b1111000;
            4'd8:    seg_next = 7'b0000000;
            4'd9:    seg_next = 7'b0010000;
            4'd10:   seg_next = 7'b0001000; // Shown as A
            default: seg_next = 7'b1111111; // Blank
        endcase
    end

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            seg_display <= 7'b0000000; // Digit 8, the reset level
        end else begin
            seg_display <= seg_next;
        end
    end

endmodule

/* source/tick_divider.sv */
`timescale 1ns/1ps
`include "pet_defines.svh"

module tick_divider #(
    parameter int DIVISOR = `PET_TICK_DIVISOR
) (
    input  logic clk,
    input  logic btn_reset,
    output logic tick
);

    localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

    logic [CNT_W-1:0] count;
    logic             wrap;

    assign wrap = (count == CNT_W'(DIVISOR - 1)); // Last cycle of a period

    always_ff @(posedge clk) begin
        if (!btn_reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            count <= wrap ? '0 : count + 1'b1;
            tick  <= wrap; // Registered, so first tick lands DIVISOR cycles out
        end
    end

endmodule

/* verilog.f */
+incdir+source
source/pet_pkg.sv
source/tick_divider.sv
source/input_sync.sv
source/need_counter.sv
source/pet_core.sv
source/seven_seg_encoder.sv
source/pet_top.sv
dv/pet_top_tb.sv
